// ==== compile.f ====
csr_pkg.sv
zicsr_decoder.sv
irq_pending.sv
machine_csr_file.sv
csr_unit.sv
csr_unit_asserts.sv
tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - zicsr_decoder.sv
  - irq_pending.sv
  - machine_csr_file.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_unit_asserts.sv
      - tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for csr_unit, one task per checked behavior
//////////////////////////////////////////////////////////////////////

module tb_csr_unit;
    import csr_pkg::*;

    localparam int          CLK_PERIOD       = 100;
    localparam int          RESET_CYCLES     = 16;
    localparam int unsigned HART_ID          = 5;
    localparam int          SYNC_DEPTH       = 2;
    localparam int          NUM_TESTS        = 6;
    localparam int          TEST_CYCLE_BOUND = 200;
    localparam int          WB_TIMEOUT       = 8;
    localparam int          TIME_GAP         = 37;
    localparam logic [4:0]  RD_IDX           = 5'd9;
    localparam logic [6:0]  OPCODE_SYSTEM    = 7'h73;

    logic            aclk;
    logic            aresetn;
    logic            valid;
    csr_instr_t      instr;
    logic [4:0]      rs1_addr;
    logic [XLEN-1:0] rs1_val;
    irq_t            irq;
    trap_wr_t        trap_wr;
    logic            rd_wr_en;
    logic [4:0]      rd_wr_addr;
    logic [XLEN-1:0] rd_wr_val;
    csr_sb_t         csr_sb;

    integer          seed = 32'h83ac;
    int              err_count = 0;
    // Reference copies of the writable CSRs
    logic [XLEN-1:0] ref_mscratch;
    logic [XLEN-1:0] ref_mtvec;
    logic [XLEN-1:0] ref_mepc;

    csr_unit #(
        .HART_ID    (HART_ID),
        .SYNC_DEPTH (SYNC_DEPTH)
    ) i_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .instr      (instr),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .irq        (irq),
        .trap_wr    (trap_wr),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .csr_sb     (csr_sb)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Bound from the test count, a stuck run ends here
    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLE_BOUND) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $fatal(1);
    end

    // Bound assertion failures stop the run at the next edge
    always @(posedge aclk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            fail_text("A bound assertion on csr_unit failed");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and reference rules
    //////////////////////////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        err_count++;
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act === exp) else fail_value(name, exp, act);
    endtask

    // Zicsr result, low funct3 bits pick write, set or clear
    function automatic logic [XLEN-1:0] rmw_result(input logic [2:0] f3,
                                                   input logic [XLEN-1:0] old,
                                                   input logic [XLEN-1:0] operand);
        case (f3[1:0])
            2'b10:   return old | operand;
            2'b11:   return old & ~operand;
            default: return operand;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Strobe driving and write-back collection
    //////////////////////////////////////////////////////////////////////

    task automatic drive_strobe(input logic [2:0] f3, input logic [11:0] addr,
                                input logic [4:0] src, input logic [XLEN-1:0] rs1v);
        @(posedge aclk);
        valid   <= 1'b1;
        instr   <= {addr, src, f3, RD_IDX, OPCODE_SYSTEM};
        rs1_val <= rs1v;
    endtask

    // Ends the strobe, then waits for the write-back of the last one
    task automatic finish_strobe(output logic [XLEN-1:0] old);
        int waited;
        @(posedge aclk);
        valid   <= 1'b0;
        trap_wr <= '0;
        waited = 0;
        @(negedge aclk);
        while (!rd_wr_en && waited < WB_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        assert (rd_wr_en) else fail_text("No rd write-back arrived after a CSR strobe");
        assert (rd_wr_addr == RD_IDX) else fail_value("rd_wr_addr", XLEN'(RD_IDX),
                                                      XLEN'(rd_wr_addr));
        old = rd_wr_val;
    endtask

    task automatic csr_op(input string name, input logic [2:0] f3, input logic [11:0] addr,
                          input logic [4:0] src, input logic [XLEN-1:0] rs1v,
                          input logic [XLEN-1:0] exp_old);
        logic [XLEN-1:0] old;
        drive_strobe(f3, addr, src, rs1v);
        // rs1 read port follows the strobe in the same cycle
        @(negedge aclk);
        assert (rs1_addr == src) else fail_value({name, " rs1_addr"}, XLEN'(src),
                                                 XLEN'(rs1_addr));
        finish_strobe(old);
        check_value(name, exp_old, old);
    endtask

    // Read through CSRRS with x0, no write
    task automatic expect_csr(input string name, input logic [11:0] addr,
                              input logic [XLEN-1:0] exp);
        csr_op(name, FUNCT3_CSRRS, addr, 5'd0, '0, exp);
    endtask

    // Plain read/write CSRs only, no legalization here
    task automatic rmw_check(input string name, input logic [2:0] f3, input logic [11:0] addr,
                             input logic [4:0] src, input logic [XLEN-1:0] rs1v,
                             inout logic [XLEN-1:0] ref_val);
        logic [XLEN-1:0] operand;
        logic            writes;
        operand = f3[2] ? {{(XLEN-5){1'b0}}, src} : rs1v;
        // Set and clear with x0 or zimm 0 leave the CSR alone
        writes  = (f3[1:0] == 2'b01) || (src != 5'd0);
        csr_op(name, f3, addr, src, rs1v, ref_val);
        if (writes) begin
            ref_val = rmw_result(f3, ref_val, operand);
        end
    endtask

    task automatic back_to_back_write(input string name, input logic [11:0] addr,
                                      input logic [XLEN-1:0] first_val,
                                      input logic [XLEN-1:0] second_val,
                                      input logic [XLEN-1:0] exp_old);
        logic [XLEN-1:0] old;
        drive_strobe(FUNCT3_CSRRW, addr, 5'd1, first_val);
        drive_strobe(FUNCT3_CSRRW, addr, 5'd2, second_val);
        @(negedge aclk);
        assert (rd_wr_en) else fail_text("No rd write-back for the first of two strobes");
        check_value({name, " first"}, exp_old, rd_wr_val);
        // Second strobe sees the value of the first
        finish_strobe(old);
        check_value({name, " second"}, first_val, old);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_readonly();
        logic [XLEN-1:0] r;
        expect_csr("reset mstatus", CSR_MSTATUS, '0);
        expect_csr("reset mie", CSR_MIE, '0);
        expect_csr("reset mscratch", CSR_MSCRATCH, '0);
        expect_csr("misa", CSR_MISA, MISA_VALUE);
        expect_csr("mhartid", CSR_MHARTID, XLEN'(HART_ID));
        r = $random(seed);
        csr_op("misa write", FUNCT3_CSRRW, CSR_MISA, 5'd3, r, MISA_VALUE);
        expect_csr("misa after write", CSR_MISA, MISA_VALUE);
    endtask

    task automatic test_reg_forms();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        ref_mscratch = '0;
        a = $random(seed);
        rmw_check("csrrw mscratch", FUNCT3_CSRRW, CSR_MSCRATCH, 5'd5, a, ref_mscratch);
        a = $random(seed);
        rmw_check("csrrs mscratch", FUNCT3_CSRRS, CSR_MSCRATCH, 5'd6, a, ref_mscratch);
        a = $random(seed);
        rmw_check("csrrc mscratch", FUNCT3_CSRRC, CSR_MSCRATCH, 5'd7, a, ref_mscratch);
        // Junk on rs1_val, x0 must still suppress the write
        a = $random(seed);
        rmw_check("csrrs x0 mscratch", FUNCT3_CSRRS, CSR_MSCRATCH, 5'd0, a, ref_mscratch);
        rmw_check("csrrc x0 mscratch", FUNCT3_CSRRC, CSR_MSCRATCH, 5'd0, a, ref_mscratch);
        expect_csr("mscratch readback", CSR_MSCRATCH, ref_mscratch);
        a = $random(seed);
        b = $random(seed);
        back_to_back_write("b2b mscratch", CSR_MSCRATCH, a, b, ref_mscratch);
        ref_mscratch = b;
        expect_csr("mscratch after b2b", CSR_MSCRATCH, ref_mscratch);
    endtask

    task automatic test_imm_forms();
        logic [XLEN-1:0] r;
        ref_mtvec = '0;
        r = $random(seed);
        rmw_check("csrrw mtvec", FUNCT3_CSRRW, CSR_MTVEC, 5'd4, r, ref_mtvec);
        // rs1_val carries junk, immediate forms must ignore it
        r = $random(seed);
        rmw_check("csrrsi mtvec", FUNCT3_CSRRSI, CSR_MTVEC, r[4:0] | 5'd1, ~r, ref_mtvec);
        r = $random(seed);
        rmw_check("csrrci mtvec", FUNCT3_CSRRCI, CSR_MTVEC, r[4:0] | 5'd1, ~r, ref_mtvec);
        r = $random(seed);
        rmw_check("csrrwi mtvec", FUNCT3_CSRRWI, CSR_MTVEC, r[4:0], ~r, ref_mtvec);
        rmw_check("csrrsi 0 mtvec", FUNCT3_CSRRSI, CSR_MTVEC, 5'd0, r, ref_mtvec);
        rmw_check("csrrci 0 mtvec", FUNCT3_CSRRCI, CSR_MTVEC, 5'd0, r, ref_mtvec);
        expect_csr("mtvec readback", CSR_MTVEC, ref_mtvec);
    endtask

    task automatic test_legalize_trap();
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] trap_pc;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] old;
        csr_op("mstatus ones", FUNCT3_CSRRW, CSR_MSTATUS, 5'd1, '1, '0);
        expect_csr("mstatus legal", CSR_MSTATUS, 32'hFFFF_FFFF & MSTATUS_MASK);
        v = $random(seed);
        csr_op("mepc write", FUNCT3_CSRRW, CSR_MEPC, 5'd2, v, '0);
        ref_mepc = {v[XLEN-1:2], 2'b00};
        expect_csr("mepc aligned", CSR_MEPC, ref_mepc);
        // Trap entry in the same cycle as an instruction write to mepc
        trap_pc = $random(seed);
        cause   = 32'h8000_000B;
        v       = $random(seed);
        drive_strobe(FUNCT3_CSRRW, CSR_MEPC, 5'd3, v);
        trap_wr.mepc_wr   <= 1'b1;
        trap_wr.mepc      <= trap_pc;
        trap_wr.mcause_wr <= 1'b1;
        trap_wr.mcause    <= cause;
        finish_strobe(old);
        check_value("mepc old at trap", ref_mepc, old);
        ref_mepc = {trap_pc[XLEN-1:2], 2'b00};
        expect_csr("mepc trap wins", CSR_MEPC, ref_mepc);
        expect_csr("mcause trap", CSR_MCAUSE, cause);
        // Shared bus mirrors the registers
        check_value("sb mtvec", ref_mtvec, csr_sb.mtvec);
        check_value("sb mepc", ref_mepc, csr_sb.mepc);
        check_value("sb mstatus", MSTATUS_MASK, csr_sb.mstatus);
    endtask

    task automatic test_interrupts();
        logic [XLEN-1:0] en_bits;
        en_bits          = '0;
        en_bits[MIE_MEI] = 1'b1;
        en_bits[MIE_MTI] = 1'b1;
        // Software interrupt left disabled
        csr_op("mie write", FUNCT3_CSRRW, CSR_MIE, 5'd1, en_bits, '0);
        @(posedge aclk);
        irq <= 3'b111;
        // Sampling edge counts as the first of SYNC_DEPTH+1
        repeat (SYNC_DEPTH) @(posedge aclk);
        @(negedge aclk);
        check_value("pending early", '0, XLEN'({csr_sb.meip, csr_sb.mtip, csr_sb.msip}));
        @(posedge aclk);
        @(negedge aclk);
        check_value("pending set", 32'b110, XLEN'({csr_sb.meip, csr_sb.mtip, csr_sb.msip}));
        expect_csr("mip pending", CSR_MIP, en_bits);
        // mtip follows the pin, meip stays
        @(posedge aclk);
        irq <= '0;
        repeat (SYNC_DEPTH + 1) @(posedge aclk);
        @(negedge aclk);
        check_value("pins dropped", 32'b100, XLEN'({csr_sb.meip, csr_sb.mtip, csr_sb.msip}));
        @(posedge aclk);
        trap_wr.clr_meip <= 1'b1;
        @(posedge aclk);
        trap_wr <= '0;
        @(negedge aclk);
        check_value("meip cleared", '0, XLEN'({csr_sb.meip, csr_sb.mtip, csr_sb.msip}));
        expect_csr("mip cleared", CSR_MIP, '0);
    endtask

    task automatic test_time_counter();
        logic [XLEN-1:0] t0;
        logic [XLEN-1:0] t1;
        // Counter far below 2^32 this early in the run
        expect_csr("timeh", CSR_TIMEH, '0);
        expect_csr("cycleh", CSR_CYCLEH, '0);
        drive_strobe(FUNCT3_CSRRS, CSR_TIME, 5'd0, '0);
        finish_strobe(t0);
        // Second read sampled TIME_GAP edges after the first
        repeat (TIME_GAP - 2) @(posedge aclk);
        drive_strobe(FUNCT3_CSRRS, CSR_TIME, 5'd0, '0);
        finish_strobe(t1);
        check_value("time delta", XLEN'(TIME_GAP), t1 - t0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        aresetn <= 1'b0;
        valid   <= 1'b0;
        instr   <= '0;
        rs1_val <= '0;
        irq     <= '0;
        trap_wr <= '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        test_reset_readonly();
        test_reg_forms();
        test_imm_forms();
        test_legalize_trap();
        test_interrupts();
        test_time_counter();
        if (err_count == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_unit_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the CSR unit, bound into every csr_unit
//////////////////////////////////////////////////////////////////////

module csr_unit_asserts
    import csr_pkg::*;
(
    input logic    aclk,
    input logic    aresetn,
    input logic    valid,
    input logic    rd_wr_en,
    input csr_sb_t csr_sb
);

    // Number of failed properties so far
    int unsigned fail_count = 0;

    // Write-back follows each strobe by exactly one cycle
    wb_follows_valid: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en == $past(valid)
    ) else begin
        $error("rd_wr_en does not follow valid by one cycle");
        fail_count++;
    end

    // mepc stays word aligned
    mepc_aligned: assert property (
        @(posedge aclk) disable iff (!aresetn) csr_sb.mepc[1:0] == 2'b00
    ) else begin
        $error("mepc on the shared bus has nonzero low bits");
        fail_count++;
    end

    // Only MIE, MPIE and MPP may be set
    mstatus_legal: assert property (
        @(posedge aclk) disable iff (!aresetn) (csr_sb.mstatus & ~MSTATUS_MASK) == '0
    ) else begin
        $error("mstatus holds bits outside the legal mask");
        fail_count++;
    end

endmodule

bind csr_unit csr_unit_asserts i_asserts (.*);

// ==== csr_unit.sv ====
//////////////////////////////////////////////////////////////////////
// CSR unit top, decoder, machine CSR file and interrupt pending
//////////////////////////////////////////////////////////////////////

module csr_unit
    import csr_pkg::*;
#(
    parameter int unsigned HART_ID    = 0,
    parameter int          SYNC_DEPTH = 2
) (
    input  logic            aclk,
    input  logic            aresetn,
    // Instruction strobe, no back-pressure
    input  logic            valid,
    input  csr_instr_t      instr,
    // rs1 read port of the core register file
    output logic [4:0]      rs1_addr,
    input  logic [XLEN-1:0] rs1_val,
    // Asynchronous interrupt pins
    input  irq_t            irq,
    // Controller trap entry
    input  trap_wr_t        trap_wr,
    // rd write-back
    output logic            rd_wr_en,
    output logic [4:0]      rd_wr_addr,
    output logic [XLEN-1:0] rd_wr_val,
    output csr_sb_t         csr_sb
);

    csr_req_t        csr_req;
    irq_t            pend;
    logic [XLEN-1:0] mie;

    zicsr_decoder i_decoder (
        .valid    (valid),
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .csr_req  (csr_req)
    );

    irq_pending #(
        .SYNC_DEPTH (SYNC_DEPTH)
    ) i_irq_pending (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .irq      (irq),
        .mie      (mie),
        .clr_meip (trap_wr.clr_meip),
        .pend     (pend)
    );

    machine_csr_file #(
        .HART_ID (HART_ID)
    ) i_csr_file (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .csr_req    (csr_req),
        .trap_wr    (trap_wr),
        .pend       (pend),
        .mie        (mie),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .csr_sb     (csr_sb)
    );

endmodule

// ==== machine_csr_file.sv ====
//////////////////////////////////////////////////////////////////////
// Machine-mode CSRs with read-modify-write update and rd write-back
//////////////////////////////////////////////////////////////////////

module machine_csr_file
    import csr_pkg::*;
#(
    parameter int unsigned HART_ID = 0
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  csr_req_t        csr_req,
    input  trap_wr_t        trap_wr,
    input  irq_t            pend,
    output logic [XLEN-1:0] mie,
    output logic            rd_wr_en,
    output logic [4:0]      rd_wr_addr,
    output logic [XLEN-1:0] rd_wr_val,
    output csr_sb_t         csr_sb
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mip;
    logic [63:0]     time_q;

    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic            csr_wren;

    // mip is a view of the pending logic
    always_comb begin
        mip          = '0;
        mip[MIE_MEI] = pend.ext;
        mip[MIE_MTI] = pend.timer;
        mip[MIE_MSI] = pend.sw;
    end

    ////////////////////////////////////////////////////////////////////
    // Read mux and new value
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_req.addr)
            CSR_MSTATUS:          old_val = mstatus;
            CSR_MISA:             old_val = MISA_VALUE;
            CSR_MIE:              old_val = mie;
            CSR_MTVEC:            old_val = mtvec;
            CSR_MSCRATCH:         old_val = mscratch;
            CSR_MEPC:             old_val = mepc;
            CSR_MCAUSE:           old_val = mcause;
            CSR_MTVAL:            old_val = mtval;
            CSR_MIP:              old_val = mip;
            CSR_MHARTID:          old_val = XLEN'(HART_ID);
            CSR_CYCLE, CSR_TIME:  old_val = time_q[31:0];
            CSR_CYCLEH, CSR_TIMEH: old_val = time_q[63:32];
            default:              old_val = '0;
        endcase
    end

    always_comb begin
        case (csr_req.op)
            CSR_SET:   new_val = old_val | csr_req.operand;
            CSR_CLEAR: new_val = old_val & ~csr_req.operand;
            default:   new_val = csr_req.operand;
        endcase
    end

    assign csr_wren = csr_req.valid & csr_req.wr;

    ////////////////////////////////////////////////////////////////////
    // Writable CSRs, trap writes win over instruction writes
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            // Only MIE, MPIE and MPP survive
            if (trap_wr.mstatus_wr) begin
                mstatus <= trap_wr.mstatus & MSTATUS_MASK;
            end else if (csr_wren && csr_req.addr == CSR_MSTATUS) begin
                mstatus <= new_val & MSTATUS_MASK;
            end
            // IALIGN is 32, low bits forced to zero
            if (trap_wr.mepc_wr) begin
                mepc <= {trap_wr.mepc[XLEN-1:2], 2'b00};
            end else if (csr_wren && csr_req.addr == CSR_MEPC) begin
                mepc <= {new_val[XLEN-1:2], 2'b00};
            end
            if (trap_wr.mcause_wr) begin
                mcause <= trap_wr.mcause;
            end else if (csr_wren && csr_req.addr == CSR_MCAUSE) begin
                mcause <= new_val;
            end
            // Plain read/write registers
            if (csr_wren && csr_req.addr == CSR_MIE) begin
                mie <= new_val;
            end
            if (csr_wren && csr_req.addr == CSR_MTVEC) begin
                mtvec <= new_val;
            end
            if (csr_wren && csr_req.addr == CSR_MSCRATCH) begin
                mscratch <= new_val;
            end
            if (csr_wren && csr_req.addr == CSR_MTVAL) begin
                mtval <= new_val;
            end
        end
    end

    // Free-running counter behind both cycle and time
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            time_q <= '0;
        end else begin
            time_q <= time_q + 64'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // rd write-back, one cycle after the strobe
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_wr_en <= 1'b0;
        end else begin
            rd_wr_en <= csr_req.valid;
        end
    end

    // Old value, captured before this edge's update lands
    always_ff @(posedge aclk) begin
        rd_wr_addr <= csr_req.rd;
        rd_wr_val  <= old_val;
    end

    // Shared bus
    assign csr_sb.mtvec   = mtvec;
    assign csr_sb.mepc    = mepc;
    assign csr_sb.mstatus = mstatus;
    assign csr_sb.meip    = pend.ext;
    assign csr_sb.mtip    = pend.timer;
    assign csr_sb.msip    = pend.sw;

endmodule

// ==== irq_pending.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt pin synchronizers and machine pending bits
//////////////////////////////////////////////////////////////////////

module irq_pending
    import csr_pkg::*;
#(
    parameter int SYNC_DEPTH = 2
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  irq_t            irq,
    input  logic [XLEN-1:0] mie,
    input  logic            clr_meip,
    output irq_t            pend
);

    // Flop chain per pin, index 0 samples the raw pins
    irq_t sync_q [SYNC_DEPTH];
    irq_t irq_sync;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < SYNC_DEPTH; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= irq;
            for (int i = 1; i < SYNC_DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign irq_sync = sync_q[SYNC_DEPTH-1];

    ////////////////////////////////////////////////////////////////////
    // Pending bits, set on edge SYNC_DEPTH+1 counting the sampling edge
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pend <= '0;
        end else begin
            // External stays pending until the controller clears it
            if (mie[MIE_MEI] && irq_sync.ext) begin
                pend.ext <= 1'b1;
            end else if (clr_meip) begin
                pend.ext <= 1'b0;
            end
            // Timer and software track the enabled pin level
            pend.timer <= mie[MIE_MTI] & irq_sync.timer;
            pend.sw    <= mie[MIE_MSI] & irq_sync.sw;
        end
    end

endmodule

// ==== zicsr_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Zicsr decode, turns the instruction strobe into a CSR request
//////////////////////////////////////////////////////////////////////

module zicsr_decoder
    import csr_pkg::*;
(
    input  logic            valid,
    input  csr_instr_t      instr,
    output logic [4:0]      rs1_addr,
    input  logic [XLEN-1:0] rs1_val,
    output csr_req_t        csr_req
);

    logic [XLEN-1:0] zimm_ext;
    logic            src_nonzero;
    csr_op_t         op;
    logic            wr;

    // Register file read goes out in the same cycle as the strobe
    assign rs1_addr = instr.rs1;

    // Immediate forms carry zimm in the rs1 slot
    assign zimm_ext    = {{(XLEN-5){1'b0}}, instr.rs1};
    // Same test for x0 and for a zero zimm
    assign src_nonzero = (instr.rs1 != 5'd0);

    // Operation and write intent
    always_comb begin
        op = CSR_WRITE;
        wr = 1'b0;
        case (instr.funct3)
            FUNCT3_CSRRW, FUNCT3_CSRRWI: begin
                op = CSR_WRITE;
                wr = 1'b1;
            end
            // Set and clear only write with a nonzero source
            FUNCT3_CSRRS, FUNCT3_CSRRSI: begin
                op = CSR_SET;
                wr = src_nonzero;
            end
            FUNCT3_CSRRC, FUNCT3_CSRRCI: begin
                op = CSR_CLEAR;
                wr = src_nonzero;
            end
            // Not a CSR form, read only
            default: begin
                op = CSR_WRITE;
                wr = 1'b0;
            end
        endcase
    end

    // funct3[2] marks the immediate forms
    assign csr_req.valid   = valid;
    assign csr_req.addr    = instr.csr;
    assign csr_req.rd      = instr.rd;
    assign csr_req.op      = op;
    assign csr_req.wr      = wr;
    assign csr_req.operand = instr.funct3[2] ? zimm_ext : rs1_val;

endmodule

// ==== csr_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared constants and packed types of the machine-mode CSR unit
//////////////////////////////////////////////////////////////////////

package csr_pkg;

    // Register width, RV32 only
    localparam int XLEN = 32;

    // Machine information and trap setup
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MIE      = 12'h304;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    // Trap handling
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_MIP      = 12'h344;
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;
    // Counter halves, cycle and time share one counter
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_TIME     = 12'hC01;
    localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [11:0] CSR_TIMEH    = 12'hC81;

    // Interrupt bit positions, same in mie and mip
    localparam int MIE_MSI = 3;
    localparam int MIE_MTI = 7;
    localparam int MIE_MEI = 11;

    // Legal mstatus bits: MIE, MPIE and MPP
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;
    // MXL = 1, I extension only
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_0100;

    // Zicsr funct3 encodings
    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
    localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
    localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
    localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csr_op_t;

    //////////////////////////////////////////////////////////////////////
    // Packed buses
    //////////////////////////////////////////////////////////////////////

    // I-type overlay of a SYSTEM instruction, zimm sits in rs1
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_instr_t;

    // Decoded request, decoder to register file
    typedef struct packed {
        logic            valid;
        logic [11:0]     addr;
        logic [4:0]      rd;
        csr_op_t         op;
        logic            wr;
        logic [XLEN-1:0] operand;
    } csr_req_t;

    // One bit per interrupt source
    typedef struct packed {
        logic ext;
        logic timer;
        logic sw;
    } irq_t;

    // Trap entry strobes from the controller
    typedef struct packed {
        logic            mepc_wr;
        logic [XLEN-1:0] mepc;
        logic            mcause_wr;
        logic [XLEN-1:0] mcause;
        logic            mstatus_wr;
        logic [XLEN-1:0] mstatus;
        logic            clr_meip;
    } trap_wr_t;

    // CSR state exported to the rest of the core
    typedef struct packed {
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mstatus;
        logic            meip;
        logic            mtip;
        logic            msip;
    } csr_sb_t;

endpackage
